//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fp compare unit testbench with verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	-f vlog.f \
	--top-module fp_cmp_unit_tb \
	-Mdir "$BUILD_DIR"

# a failing run exits non-zero, the log decides the outcome
"./$BUILD_DIR/Vfp_cmp_unit_tb" | tee "$LOG"

if grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi

//--- src/fcmp_pkg.sv
package fcmp_pkg;

	// ====================
	// condition vector
	// ====================

	// lower byte holds the predicates, upper byte their complements
	localparam int CMP_VEC_W = 16;

	typedef logic [CMP_VEC_W-1:0] cmp_vec_t;

	// reserved positions 5..7 and 13..15, always zero in the vector
	localparam cmp_vec_t CMP_RSVD_MASK = 16'hE0E0;

	// ====================
	// condition codes
	// ====================

	// code value is the vector bit position it selects
	typedef enum logic [3:0] {
		CMP_EQ  = 4'd0,
		CMP_LT  = 4'd1,
		CMP_LE  = 4'd2,
		// magnitude less than, sign ignored
		CMP_MLT = 4'd3,
		// unordered, at least one nan
		CMP_UN  = 4'd4,
		CMP_NE  = 4'd8,
		CMP_GE  = 4'd9,
		CMP_GT  = 4'd10,
		CMP_MGE = 4'd11,
		// ordered, no nan
		CMP_OR  = 4'd12
	} cmp_cond_e;

	// relational predicates signal invalid on any nan, quiet ones included
	// eq / ne / un / or and the magnitude tests stay quiet
	function automatic logic cmp_is_signaling(cmp_cond_e cond);
		return cond inside {CMP_LT, CMP_LE, CMP_GE, CMP_GT};
	endfunction

endpackage

//--- src/fp32_pkg.sv
package fp32_pkg;

	// ====================
	// ieee 754 single precision format
	// ====================

	// exponent field width
	localparam int EXP_W = 8;
	// fraction field width, hidden bit not stored
	localparam int MAN_W = 23;
	// whole word: sign + exponent + fraction
	localparam int FP32_W = 1 + EXP_W + MAN_W;

	// top fraction bit, set for a quiet nan and clear for a signaling nan
	localparam int QNAN_BIT = MAN_W - 1;

	// ====================
	// operand views
	// ====================

	// field layout, msb first as stored in memory
	typedef struct packed {
		logic             sgn;
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] man;
	} fp32_fields_t;

	// one 32-bit word, decoded two ways
	// bits for the bitwise equality test
	// f for sign / exponent / fraction extraction
	typedef union packed {
		logic [FP32_W-1:0] bits;
		fp32_fields_t      f;
	} fp32_t;

endpackage

//--- src/fp_cmp_select.sv
`timescale 1ns/1ps

module fp_cmp_select
	import fcmp_pkg::*;
#(
	parameter int TAG_W = 4
)
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             clr_sticky,
	input  logic             s1_valid,
	input  logic [TAG_W-1:0] s1_tag,
	input  cmp_cond_e        s1_cond,
	input  cmp_vec_t         s1_vec,
	input  logic             s1_nan,
	input  logic             s1_snan,
	output logic             out_valid,
	output logic [TAG_W-1:0] out_tag,
	output cmp_vec_t         out_vec,
	output logic             out_result,
	output logic             out_invalid,
	output logic             sticky_invalid
);

	// predicate bit picked by the condition code
	logic sel_bit;
	// invalid for the request now in stage two
	logic inv_now;

	// ====================
	// select and invalid
	// ====================

	// code value doubles as bit position
	assign sel_bit = s1_vec[s1_cond];

	// snan always invalid, qnan only under lt / le / ge / gt
	assign inv_now = s1_valid & (s1_snan | (s1_nan & cmp_is_signaling(s1_cond)));

	// ====================
	// output register
	// ====================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid   <= 1'b0;
			out_invalid <= 1'b0;
		end
		else
		begin
			out_valid   <= s1_valid;
			out_invalid <= inv_now;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			out_tag    <= s1_tag;
			out_vec    <= s1_vec;
			out_result <= sel_bit;
		end
	end

	// sticky rises alongside out_invalid
	// a new invalid beats a clear in the same cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			sticky_invalid <= 1'b0;
		else
			sticky_invalid <= inv_now | (sticky_invalid & ~clr_sticky);
	end

	// code must name a defined predicate, reserved bits are always zero
	a_cond_defined: assert property (
		@(posedge clk) disable iff (!rst_n)
		s1_valid |-> !CMP_RSVD_MASK[s1_cond]
	);

endmodule

//--- src/fp_cmp_unit.sv
`timescale 1ns/1ps

module fp_cmp_unit
	import fp32_pkg::*;
	import fcmp_pkg::*;
#(
	parameter int TAG_W = 4
)
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [TAG_W-1:0] in_tag,
	input  fp32_t            in_a,
	input  fp32_t            in_b,
	input  cmp_cond_e        in_cond,
	input  logic             clr_sticky,
	output logic             out_valid,
	output logic [TAG_W-1:0] out_tag,
	output cmp_vec_t         out_vec,
	output logic             out_result,
	output logic             out_invalid,
	output logic             sticky_invalid
);

	// ====================
	// stage one to stage two
	// ====================

	logic             s1_valid;
	logic [TAG_W-1:0] s1_tag;
	cmp_cond_e        s1_cond;
	cmp_vec_t         s1_vec;
	logic             s1_nan;
	logic             s1_snan;

	// decompose, compare, build vector
	fp_compare32 #(
		.TAG_W (TAG_W)
	) u_compare (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_tag   (in_tag),
		.in_a     (in_a),
		.in_b     (in_b),
		.in_cond  (in_cond),
		.s1_valid (s1_valid),
		.s1_tag   (s1_tag),
		.s1_cond  (s1_cond),
		.s1_vec   (s1_vec),
		.s1_nan   (s1_nan),
		.s1_snan  (s1_snan)
	);

	// predicate pick, invalid and sticky flag
	fp_cmp_select #(
		.TAG_W (TAG_W)
	) u_select (
		.clk            (clk),
		.rst_n          (rst_n),
		.clr_sticky     (clr_sticky),
		.s1_valid       (s1_valid),
		.s1_tag         (s1_tag),
		.s1_cond        (s1_cond),
		.s1_vec         (s1_vec),
		.s1_nan         (s1_nan),
		.s1_snan        (s1_snan),
		.out_valid      (out_valid),
		.out_tag        (out_tag),
		.out_vec        (out_vec),
		.out_result     (out_result),
		.out_invalid    (out_invalid),
		.sticky_invalid (sticky_invalid)
	);

endmodule

//--- src/fp_compare32.sv
`timescale 1ns/1ps

module fp_compare32
	import fp32_pkg::*;
	import fcmp_pkg::*;
#(
	parameter int TAG_W = 4
)
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic [TAG_W-1:0] in_tag,
	input  fp32_t            in_a,
	input  fp32_t            in_b,
	input  cmp_cond_e        in_cond,
	output logic             s1_valid,
	output logic [TAG_W-1:0] s1_tag,
	output cmp_cond_e        s1_cond,
	output cmp_vec_t         s1_vec,
	output logic             s1_nan,
	output logic             s1_snan
);

	// decomposed operand a
	logic             sa;
	logic [EXP_W-1:0] xa;
	logic [MAN_W-1:0] ma;
	logic             az, qnan_a, snan_a;
	// decomposed operand b
	logic             sb;
	logic [EXP_W-1:0] xb;
	logic [MAN_W-1:0] mb;
	logic             bz, qnan_b, snan_b;

	logic     unordered;
	logic     same_val;
	logic     mag_lt, mag_gt;
	logic     lt_raw;
	logic     eq, lt, le;
	cmp_vec_t vec;

	// infinity needs no special case here
	// exponent all ones already orders it above every finite value
	fp_decomp32 u_decomp_a (
		.op      (in_a),
		.sgn     (sa),
		.exp     (xa),
		.man     (ma),
		.is_zero (az),
		.is_inf  (),
		.is_qnan (qnan_a),
		.is_snan (snan_a)
	);

	fp_decomp32 u_decomp_b (
		.op      (in_b),
		.sgn     (sb),
		.exp     (xb),
		.man     (mb),
		.is_zero (bz),
		.is_inf  (),
		.is_qnan (qnan_b),
		.is_snan (snan_b)
	);

	// ====================
	// compare terms
	// ====================

	assign unordered = qnan_a | qnan_b | snan_a | snan_b;

	// -0 == +0, otherwise identical bit patterns
	assign same_val = (az & bz) | (in_a.bits == in_b.bits);

	// biased exponent then fraction, compares as one unsigned magnitude
	assign mag_lt = {xa, ma} < {xb, mb};
	assign mag_gt = {xa, ma} > {xb, mb};

	// mixed signs: negative one is smaller unless both are zero
	// both negative: larger magnitude is smaller
	assign lt_raw = (sa ^ sb) ? (sa & ~(az & bz)) : (sa ? mag_gt : mag_lt);

	assign eq = ~unordered & same_val;
	assign lt = ~unordered & lt_raw;
	assign le = lt | eq;

	// ====================
	// condition vector
	// ====================

	always_comb
	begin
		vec = '0;
		vec[CMP_EQ]  = eq;
		vec[CMP_LT]  = lt;
		vec[CMP_LE]  = le;
		// magnitude tests ignore nan
		vec[CMP_MLT] = mag_lt;
		vec[CMP_UN]  = unordered;
		vec[CMP_NE]  = ~same_val;
		vec[CMP_GE]  = ~lt & ~unordered;
		vec[CMP_GT]  = ~le & ~unordered;
		vec[CMP_MGE] = ~mag_lt;
		vec[CMP_OR]  = ~unordered;
	end

	// ====================
	// stage one register
	// ====================

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	// payload only loads with a request
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			s1_tag  <= in_tag;
			s1_cond <= in_cond;
			s1_vec  <= vec;
			s1_nan  <= unordered;
			s1_snan <= snan_a | snan_b;
		end
	end

	// eq and lt exclusive, and a nan never compares equal
	a_s1_vec_consistent: assert property (
		@(posedge clk) disable iff (!rst_n)
		s1_valid |-> !(s1_vec[CMP_EQ] && s1_vec[CMP_LT]) &&
			!(s1_vec[CMP_UN] && s1_vec[CMP_EQ])
	);

endmodule

//--- src/fp_decomp32.sv
`timescale 1ns/1ps

module fp_decomp32
	import fp32_pkg::*;
(
	input  fp32_t            op,
	output logic             sgn,
	output logic [EXP_W-1:0] exp,
	output logic [MAN_W-1:0] man,
	output logic             is_zero,
	output logic             is_inf,
	output logic             is_qnan,
	output logic             is_snan
);

	// exponent all ones: infinity or nan
	logic exp_ones;
	// exponent all zero: zero or denormal
	logic exp_zero;
	// any fraction bit set
	logic man_nz;

	// ====================
	// field split
	// ====================

	assign sgn = op.f.sgn;
	assign exp = op.f.exp;
	assign man = op.f.man;

	assign exp_ones = &op.f.exp;
	assign exp_zero = ~|op.f.exp;
	assign man_nz   = |op.f.man;

	// ====================
	// classification
	// ====================

	// +0 and -0 both count, sign not looked at
	assign is_zero = exp_zero & ~man_nz;
	assign is_inf  = exp_ones & ~man_nz;

	// nan split on the top fraction bit
	assign is_qnan = exp_ones & man_nz & op.f.man[QNAN_BIT];
	assign is_snan = exp_ones & man_nz & ~op.f.man[QNAN_BIT];

endmodule

//--- verif/fp_cmp_vectors.svh
`ifndef FP_CMP_VECTORS_SVH
`define FP_CMP_VECTORS_SVH

// columns: name, a, b, cond, expected vector, expected result, expected invalid
// clean entries first, then the invalid ones, then one clean entry to test sticky hold

string     tab_name[$];
fp32_t     tab_a[$];
fp32_t     tab_b[$];
cmp_cond_e tab_cond[$];
cmp_vec_t  tab_vec[$];
logic      tab_res[$];
logic      tab_inv[$];

task automatic add_vec(input string name, input fp32_t a, input fp32_t b,
	input cmp_cond_e cond, input cmp_vec_t vec, input logic res, input logic inv);
	tab_name.push_back(name);
	tab_a.push_back(a);
	tab_b.push_back(b);
	tab_cond.push_back(cond);
	tab_vec.push_back(vec);
	tab_res.push_back(res);
	tab_inv.push_back(inv);
endtask

task automatic load_vectors();
	// ordered pairs, same sign and mixed sign
	add_vec("pos_lt",       32'h3F800000, 32'h40000000, CMP_LT,  16'h110E, 1'b1, 1'b0);
	add_vec("pos_gt",       32'h40000000, 32'h3F800000, CMP_GT,  16'h1F00, 1'b1, 1'b0);
	add_vec("neg_le",       32'hC0000000, 32'hBF800000, CMP_LE,  16'h1906, 1'b1, 1'b0);
	add_vec("mixed_ge",     32'hBF800000, 32'h3F000000, CMP_GE,  16'h1906, 1'b0, 1'b0);
	add_vec("equal_eq",     32'h3FC00000, 32'h3FC00000, CMP_EQ,  16'h1A05, 1'b1, 1'b0);
	// +inf against -inf, equal magnitude
	add_vec("inf_gt",       32'h7F800000, 32'hFF800000, CMP_GT,  16'h1F00, 1'b1, 1'b0);
	add_vec("denorm_mlt",   32'h00000001, 32'h00000002, CMP_MLT, 16'h110E, 1'b1, 1'b0);
	// +0 and -0 are equal
	add_vec("zero_ne",      32'h00000000, 32'h80000000, CMP_NE,  16'h1A05, 1'b0, 1'b0);
	add_vec("zero_lt",      32'h80000000, 32'h00000000, CMP_LT,  16'h1A05, 1'b0, 1'b0);
	add_vec("zero_ge",      32'h80000000, 32'h00000000, CMP_GE,  16'h1A05, 1'b1, 1'b0);
	add_vec("ord_or",       32'h3F800000, 32'h40000000, CMP_OR,  16'h110E, 1'b1, 1'b0);
	add_vec("neg_mge",      32'hC0000000, 32'hBF800000, CMP_MGE, 16'h1906, 1'b1, 1'b0);
	// quiet nan under quiet predicates
	add_vec("qnan_eq",      32'h7FC00000, 32'h3F800000, CMP_EQ,  16'h0910, 1'b0, 1'b0);
	add_vec("qnan_ne",      32'h7FC00000, 32'h3F800000, CMP_NE,  16'h0910, 1'b1, 1'b0);
	add_vec("qnan_un",      32'h7FC00000, 32'h3F800000, CMP_UN,  16'h0910, 1'b1, 1'b0);
	add_vec("qnan_or",      32'h7FC00000, 32'h3F800000, CMP_OR,  16'h0910, 1'b0, 1'b0);
	add_vec("qnan_mlt",     32'h3F800000, 32'h7FC00000, CMP_MLT, 16'h0118, 1'b1, 1'b0);
	// quiet nan under relational predicates
	add_vec("qnan_lt",      32'h7FC00000, 32'h3F800000, CMP_LT,  16'h0910, 1'b0, 1'b1);
	add_vec("qnan_le",      32'h3F800000, 32'h7FC00000, CMP_LE,  16'h0118, 1'b0, 1'b1);
	add_vec("qnan_ge",      32'h3F800000, 32'h7FC00000, CMP_GE,  16'h0118, 1'b0, 1'b1);
	add_vec("qnan_gt",      32'h7FC00000, 32'h3F800000, CMP_GT,  16'h0910, 1'b0, 1'b1);
	// signaling nan is invalid under every code
	add_vec("snan_eq",      32'h7F800001, 32'h3F800000, CMP_EQ,  16'h0910, 1'b0, 1'b1);
	add_vec("snan_un",      32'h3F800000, 32'h7FA00000, CMP_UN,  16'h0118, 1'b1, 1'b1);
	add_vec("snan_or",      32'h7F800001, 32'h3F800000, CMP_OR,  16'h0910, 1'b0, 1'b1);
	add_vec("neg_mixed_lt", 32'hBF800000, 32'h3F800000, CMP_LT,  16'h1906, 1'b1, 1'b0);
endtask

`endif

//--- verif/fp_cmp_unit_tb.sv
`timescale 1ns/1ps

module fp_cmp_unit_tb
	import fp32_pkg::*;
	import fcmp_pkg::*;
();

	localparam int TAG_W = 4;
	// cycles to wait for out_valid
	localparam int OUT_TIMEOUT = 20;
	// idle cycles between spaced requests
	localparam int GAP = 3;

	logic             clk = 1'b0;
	logic             rst_n;
	logic             in_valid;
	logic [TAG_W-1:0] in_tag;
	fp32_t            in_a;
	fp32_t            in_b;
	cmp_cond_e        in_cond;
	logic             clr_sticky;
	logic             out_valid;
	logic [TAG_W-1:0] out_tag;
	cmp_vec_t         out_vec;
	logic             out_result;
	logic             out_invalid;
	logic             sticky_invalid;

	// in-flight requests matched to out_valid in order
	int               sent_q[$];
	int               cyc_q[$];
	logic [TAG_W-1:0] tag_q[$];
	logic [TAG_W-1:0] next_tag;
	logic             sticky_exp;
	int               cyc_count = 0;

	`include "fp_cmp_vectors.svh"

	fp_cmp_unit #(
		.TAG_W (TAG_W)
	) u_fp_cmp_unit (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_tag         (in_tag),
		.in_a           (in_a),
		.in_b           (in_b),
		.in_cond        (in_cond),
		.clr_sticky     (clr_sticky),
		.out_valid      (out_valid),
		.out_tag        (out_tag),
		.out_vec        (out_vec),
		.out_result     (out_result),
		.out_invalid    (out_invalid),
		.sticky_invalid (sticky_invalid)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
		cyc_count <= cyc_count + 1;

	// ====================
	// compare tasks
	// ====================

	task automatic check_vec(input string name, input cmp_vec_t exp_v, input cmp_vec_t act_v);
		if (act_v !== exp_v)
		begin
			$display("mismatch %s vector expected %h actual %h", name, exp_v, act_v);
			$display("TEST RESULT: FAIL");
			$fatal(1, "condition vector differs");
		end
	endtask

	task automatic check_bit(input string name, input logic exp_b, input logic act_b);
		if (act_b !== exp_b)
		begin
			$display("mismatch %s expected %b actual %b", name, exp_b, act_b);
			$display("TEST RESULT: FAIL");
			$fatal(1, "flag differs");
		end
	endtask

	task automatic check_tag(input string name, input logic [TAG_W-1:0] exp_t,
		input logic [TAG_W-1:0] act_t);
		if (act_t !== exp_t)
		begin
			$display("mismatch %s tag expected %h actual %h", name, exp_t, act_t);
			$display("TEST RESULT: FAIL");
			$fatal(1, "tag differs");
		end
	endtask

	task automatic check_latency(input string name, input int exp_c, input int act_c);
		if (act_c != exp_c)
		begin
			$display("mismatch %s output cycle expected %0d actual %0d", name, exp_c, act_c);
			$display("TEST RESULT: FAIL");
			$fatal(1, "latency differs");
		end
	endtask

	// ====================
	// drive and collect
	// ====================

	task automatic send_entry(input int idx);
		@(posedge clk);
		in_valid <= 1'b1;
		in_tag   <= next_tag;
		in_a     <= tab_a[idx];
		in_b     <= tab_b[idx];
		in_cond  <= tab_cond[idx];
		sent_q.push_back(idx);
		tag_q.push_back(next_tag);
		// in_valid is seen high in the next cycle
		cyc_q.push_back(cyc_count + 1);
		next_tag = next_tag + 1'b1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			in_valid <= 1'b0;
		end
	endtask

	// sample at the falling edge once outputs have settled
	task automatic wait_out_valid();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!out_valid)
		begin
			cycles++;
			if (cycles >= OUT_TIMEOUT)
			begin
				$display("out_valid did not arrive within %0d cycles", OUT_TIMEOUT);
				$display("TEST RESULT: FAIL");
				$fatal(1, "timeout waiting for a result");
			end
			@(negedge clk);
		end
	endtask

	task automatic collect_results(input int count);
		int idx;
		int sent_cyc;
		logic [TAG_W-1:0] tag;
		repeat (count)
		begin
			wait_out_valid();
			if (sent_q.size() == 0)
			begin
				$display("out_valid rose with no request in flight");
				$display("TEST RESULT: FAIL");
				$fatal(1, "unexpected result");
			end
			idx = sent_q.pop_front();
			tag = tag_q.pop_front();
			sent_cyc = cyc_q.pop_front();
			check_latency(tab_name[idx], sent_cyc + 2, cyc_count);
			check_tag(tab_name[idx], tag, out_tag);
			check_vec(tab_name[idx], tab_vec[idx], out_vec);
			check_bit({tab_name[idx], " result"}, tab_res[idx], out_result);
			check_bit({tab_name[idx], " invalid"}, tab_inv[idx], out_invalid);
			// sticky rises with the invalid result itself
			sticky_exp = sticky_exp | tab_inv[idx];
			check_bit({tab_name[idx], " sticky"}, sticky_exp, sticky_invalid);
		end
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		clr_sticky <= 1'b1;
		@(posedge clk);
		clr_sticky <= 1'b0;
		@(negedge clk);
		sticky_exp = 1'b0;
		check_bit("sticky after clear", 1'b0, sticky_invalid);
	endtask

	// ====================
	// main sequence
	// ====================

	initial
	begin
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_tag     = '0;
		in_a       = '0;
		in_b       = '0;
		in_cond    = CMP_EQ;
		clr_sticky = 1'b0;
		next_tag   = '0;
		sticky_exp = 1'b0;
		load_vectors();

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("reset out_valid", 1'b0, out_valid);
		check_bit("reset out_invalid", 1'b0, out_invalid);
		check_bit("reset sticky", 1'b0, sticky_invalid);

		// back to back with one request per cycle
		fork
			begin
				for (int i = 0; i < tab_name.size(); i++)
					send_entry(i);
				idle_cycles(1);
			end
			collect_results(tab_name.size());
		join
		pulse_clear();

		// same table spaced apart
		for (int i = 0; i < tab_name.size(); i++)
		begin
			fork
				begin
					send_entry(i);
					idle_cycles(1);
				end
				collect_results(1);
			join
			idle_cycles(GAP);
		end
		pulse_clear();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+verif
src/fp32_pkg.sv
src/fcmp_pkg.sv
src/fp_decomp32.sv
src/fp_compare32.sv
src/fp_cmp_select.sv
src/fp_cmp_unit.sv
verif/fp_cmp_unit_tb.sv
